/* src/prbs_pkg.sv */
package prbs_pkg;

    ////////////////////
    // Data path widths
    ////////////////////

    localparam int PRBS_WIDTH  = 16;                       // LFSR and data word width
    localparam int TAP_COUNT   = 4;                        // Tap slots per polynomial
    localparam int TAP_INDEX_W = 5;                        // One tap position, 0 = unused
    localparam int TAPS_W      = TAP_COUNT * TAP_INDEX_W;  // Concatenated tap slots
    localparam int CNT_W       = 16;                       // Status counter width

    // Bits needed to count every differing bit of one word, 0..PRBS_WIDTH
    localparam int ERR_BITS_W  = $clog2(PRBS_WIDTH + 1);

    ////////////////////
    // Register bus
    ////////////////////

    localparam int CFG_ADDR_W = 3;
    localparam int CFG_DATA_W = 32;

    // Register map
    localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL     = CFG_ADDR_W'(0);  // Enable, start
    localparam logic [CFG_ADDR_W-1:0] ADDR_SEED     = CFG_ADDR_W'(1);
    localparam logic [CFG_ADDR_W-1:0] ADDR_TAPS     = CFG_ADDR_W'(2);
    localparam logic [CFG_ADDR_W-1:0] ADDR_ERR_CNT  = CFG_ADDR_W'(3);  // Read only
    localparam logic [CFG_ADDR_W-1:0] ADDR_WORD_CNT = CFG_ADDR_W'(4);  // Read only
    localparam logic [CFG_ADDR_W-1:0] ADDR_WRAP_CNT = CFG_ADDR_W'(5);  // Read only

    // CTRL bit positions
    localparam int CTRL_EN_BIT    = 0;  // Stored run enable
    localparam int CTRL_START_BIT = 1;  // Write only, self clearing

endpackage : prbs_pkg

/* src/lfsr_fibonacci.sv */
`timescale 1ns/1ps

module lfsr_fibonacci #(
    parameter int WIDTH       = 16,  // State width
    parameter int TAP_COUNT   = 4,   // Number of tap slots
    parameter int TAP_INDEX_W = 5    // Bits per tap slot
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_step,       // Advance one position
    input  logic                           i_seed_load,  // Load seed, wins over step
    input  logic [WIDTH-1:0]               i_seed,
    input  logic [TAP_COUNT*TAP_INDEX_W-1:0] i_taps,     // Slot k at [k*TAP_INDEX_W +: ...]
    output logic [WIDTH-1:0]               o_state,      // Current state
    output logic [WIDTH-1:0]               o_next,       // State after one step
    output logic                           o_at_seed     // Last step landed on seed
);

    logic [WIDTH-1:0]       state_q;
    logic [WIDTH-1:0]       next_state;
    logic [WIDTH:1]         tap_mask;     // 1-based, bit p set for tap position p
    logic [TAP_INDEX_W-1:0] tap_pos;
    logic                   feedback;
    logic                   at_seed_q;

    ////////////////////
    // Tap decode
    ////////////////////

    always_comb begin
        tap_mask = '0;
        tap_pos  = '0;
        for (int k = 0; k < TAP_COUNT; k++) begin
            tap_pos = i_taps[k*TAP_INDEX_W +: TAP_INDEX_W];
            // Zero marks an empty slot, positions past the width are ignored
            if ((tap_pos != '0) && (int'(tap_pos) <= WIDTH)) begin
                tap_mask[tap_pos] = 1'b1;
            end
        end
    end

    // Position p selects state bit p-1
    assign feedback   = ^(state_q & tap_mask);
    assign next_state = {state_q[WIDTH-2:0], feedback};  // Shift up, feedback into bit 0

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q   <= '0;
            at_seed_q <= 1'b0;
        end else if (i_seed_load) begin
            state_q   <= i_seed;
            at_seed_q <= 1'b0;                     // Loading is not a wrap
        end else begin
            if (i_step) begin
                state_q <= next_state;
            end
            at_seed_q <= i_step && (next_state == i_seed);  // One cycle pulse
        end
    end

    assign o_state   = state_q;
    assign o_next    = next_state;
    assign o_at_seed = at_seed_q;

endmodule : lfsr_fibonacci

/* src/prbs_cfg_regs.sv */
`timescale 1ns/1ps

module prbs_cfg_regs (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // Configuration bus
    input  logic                             i_cfg_wr,
    input  logic                             i_cfg_rd,
    input  logic [prbs_pkg::CFG_ADDR_W-1:0]  i_cfg_addr,
    input  logic [prbs_pkg::CFG_DATA_W-1:0]  i_cfg_wdata,
    output logic [prbs_pkg::CFG_DATA_W-1:0]  o_cfg_rdata,
    output logic                             o_cfg_rvalid,
    // Control to both LFSRs
    output logic                             o_run,
    output logic                             o_seed_load,
    output logic [prbs_pkg::PRBS_WIDTH-1:0]  o_seed,
    output logic [prbs_pkg::TAPS_W-1:0]      o_taps,
    // Status events
    input  logic                             i_gen_wrap,
    input  logic                             i_rx_word,
    input  logic [prbs_pkg::ERR_BITS_W-1:0]  i_rx_err_bits
);

    import prbs_pkg::*;

    logic                  run_q;
    logic [PRBS_WIDTH-1:0] seed_q;
    logic [TAPS_W-1:0]     taps_q;
    logic                  start_wr;
    logic                  seed_load_q;

    logic [CNT_W-1:0]      err_cnt_q;
    logic [CNT_W-1:0]      word_cnt_q;
    logic [CNT_W-1:0]      wrap_cnt_q;
    logic [CNT_W:0]        err_sum;      // Extra bit catches overflow

    logic [CFG_DATA_W-1:0] rd_mux;
    logic [CFG_DATA_W-1:0] rdata_q;
    logic                  rvalid_q;

    ////////////////////
    // Writable registers
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            run_q  <= 1'b0;
            seed_q <= '0;
            taps_q <= '0;
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                ADDR_CTRL: run_q  <= i_cfg_wdata[CTRL_EN_BIT];
                ADDR_SEED: seed_q <= i_cfg_wdata[PRBS_WIDTH-1:0];
                ADDR_TAPS: taps_q <= i_cfg_wdata[TAPS_W-1:0];
                default:   ;                                       // Status is read only
            endcase
        end
    end

    // Start bit is never stored, only turned into a pulse
    assign start_wr = i_cfg_wr && (i_cfg_addr == ADDR_CTRL) && i_cfg_wdata[CTRL_START_BIT];

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            seed_load_q <= 1'b0;
        end else begin
            seed_load_q <= start_wr;  // Fires the cycle after the write
        end
    end

    ////////////////////
    // Status counters
    ////////////////////

    assign err_sum = {1'b0, err_cnt_q} + (CNT_W+1)'(i_rx_err_bits);

    // Cleared with the same pulse that reloads the LFSRs
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            err_cnt_q  <= '0;
            word_cnt_q <= '0;
            wrap_cnt_q <= '0;
        end else if (seed_load_q) begin
            err_cnt_q  <= '0;
            word_cnt_q <= '0;
            wrap_cnt_q <= '0;
        end else begin
            if (i_rx_word) begin
                err_cnt_q <= err_sum[CNT_W] ? '1 : err_sum[CNT_W-1:0];  // Saturate
                if (!(&word_cnt_q)) begin
                    word_cnt_q <= word_cnt_q + 1'b1;                     // Saturate
                end
            end
            if (i_gen_wrap) begin
                wrap_cnt_q <= wrap_cnt_q + 1'b1;  // Free running, wraps
            end
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    always_comb begin
        rd_mux = '0;  // Unmapped addresses read zero
        case (i_cfg_addr)
            ADDR_CTRL:     rd_mux[CTRL_EN_BIT]    = run_q;  // Start reads back 0
            ADDR_SEED:     rd_mux[PRBS_WIDTH-1:0] = seed_q;
            ADDR_TAPS:     rd_mux[TAPS_W-1:0]     = taps_q;
            ADDR_ERR_CNT:  rd_mux[CNT_W-1:0]      = err_cnt_q;
            ADDR_WORD_CNT: rd_mux[CNT_W-1:0]      = word_cnt_q;
            ADDR_WRAP_CNT: rd_mux[CNT_W-1:0]      = wrap_cnt_q;
            default:       ;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            rdata_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= i_cfg_rd;  // One cycle latency
            if (i_cfg_rd) begin
                rdata_q <= rd_mux;
            end
        end
    end

    assign o_cfg_rdata  = rdata_q;
    assign o_cfg_rvalid = rvalid_q;
    assign o_run        = run_q;
    assign o_seed_load  = seed_load_q;
    assign o_seed       = seed_q;
    assign o_taps       = taps_q;

endmodule : prbs_cfg_regs

/* src/prbs_checker.sv */
`timescale 1ns/1ps

module prbs_checker (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_run,        // Enable from CTRL
    input  logic                             i_seed_load,  // Realign to seed
    input  logic                             i_rx_valid,
    input  logic [prbs_pkg::PRBS_WIDTH-1:0]  i_rx_data,
    input  logic [prbs_pkg::PRBS_WIDTH-1:0]  i_seed,
    input  logic [prbs_pkg::TAPS_W-1:0]      i_taps,
    output logic                             o_word,       // One pulse per checked word
    output logic [prbs_pkg::ERR_BITS_W-1:0]  o_err_bits    // Valid with o_word
);

    import prbs_pkg::*;

    logic                  accept;
    logic [PRBS_WIDTH-1:0] exp_word;    // Expected next pattern word
    logic [PRBS_WIDTH-1:0] diff;
    logic [ERR_BITS_W-1:0] err_bits_d;
    logic                  word_q;
    logic [ERR_BITS_W-1:0] err_bits_q;

    ////////////////////
    // Reference LFSR
    ////////////////////

    // A word arriving with the seed load would be compared against a state
    // that is about to be replaced, so it is not counted
    assign accept = i_rx_valid && i_run && !i_seed_load;

    lfsr_fibonacci #(
        .WIDTH       (PRBS_WIDTH),
        .TAP_COUNT   (TAP_COUNT),
        .TAP_INDEX_W (TAP_INDEX_W)
    ) rx_lfsr_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (accept),
        .i_seed_load (i_seed_load),
        .i_seed      (i_seed),
        .i_taps      (i_taps),
        .o_state     (),           // Only the next state is compared
        .o_next      (exp_word),
        .o_at_seed   ()            // Wraps are counted on the transmit side
    );

    ////////////////////
    // Compare
    ////////////////////

    assign diff = i_rx_data ^ exp_word;  // Set bits are errors

    // Population count of the mismatch
    always_comb begin
        err_bits_d = '0;
        for (int b = 0; b < PRBS_WIDTH; b++) begin
            err_bits_d = err_bits_d + ERR_BITS_W'(diff[b]);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            word_q     <= 1'b0;
            err_bits_q <= '0;
        end else begin
            word_q <= accept;
            if (accept) begin
                err_bits_q <= err_bits_d;  // Held until the next word
            end
        end
    end

    assign o_word     = word_q;
    assign o_err_bits = err_bits_q;

endmodule : prbs_checker

/* src/prbs_top.sv */
`timescale 1ns/1ps

module prbs_top (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // Configuration bus
    input  logic                             i_cfg_wr,
    input  logic                             i_cfg_rd,
    input  logic [prbs_pkg::CFG_ADDR_W-1:0]  i_cfg_addr,
    input  logic [prbs_pkg::CFG_DATA_W-1:0]  i_cfg_wdata,
    output logic [prbs_pkg::CFG_DATA_W-1:0]  o_cfg_rdata,
    output logic                             o_cfg_rvalid,
    // Transmit side
    input  logic                             i_tx_req,
    output logic [prbs_pkg::PRBS_WIDTH-1:0]  o_tx_data,
    output logic                             o_tx_valid,
    // Receive side
    input  logic                             i_rx_valid,
    input  logic [prbs_pkg::PRBS_WIDTH-1:0]  i_rx_data
);

    import prbs_pkg::*;

    logic                  run;
    logic                  seed_load;
    logic [PRBS_WIDTH-1:0] cfg_seed;
    logic [TAPS_W-1:0]     cfg_taps;
    logic                  gen_wrap;
    logic                  gen_step;
    logic                  tx_valid_q;
    logic                  rx_word;
    logic [ERR_BITS_W-1:0] rx_err_bits;

    prbs_cfg_regs cfg_regs_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg_rd      (i_cfg_rd),
        .i_cfg_addr    (i_cfg_addr),
        .i_cfg_wdata   (i_cfg_wdata),
        .o_cfg_rdata   (o_cfg_rdata),
        .o_cfg_rvalid  (o_cfg_rvalid),
        .o_run         (run),
        .o_seed_load   (seed_load),
        .o_seed        (cfg_seed),
        .o_taps        (cfg_taps),
        .i_gen_wrap    (gen_wrap),
        .i_rx_word     (rx_word),
        .i_rx_err_bits (rx_err_bits)
    );

    ////////////////////
    // Generator
    ////////////////////

    assign gen_step = i_tx_req && run;  // Requests while disabled are dropped

    lfsr_fibonacci #(
        .WIDTH       (PRBS_WIDTH),
        .TAP_COUNT   (TAP_COUNT),
        .TAP_INDEX_W (TAP_INDEX_W)
    ) gen_lfsr_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (gen_step),
        .i_seed_load (seed_load),
        .i_seed      (cfg_seed),
        .i_taps      (cfg_taps),
        .o_state     (o_tx_data),  // New word is in the state after the step
        .o_next      (),
        .o_at_seed   (gen_wrap)
    );

    // Valid lines up with the updated state
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= gen_step;
        end
    end

    assign o_tx_valid = tx_valid_q;

    prbs_checker checker_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_run       (run),
        .i_seed_load (seed_load),
        .i_rx_valid  (i_rx_valid),
        .i_rx_data   (i_rx_data),
        .i_seed      (cfg_seed),
        .i_taps      (cfg_taps),
        .o_word      (rx_word),
        .o_err_bits  (rx_err_bits)
    );

endmodule : prbs_top

/* verification/prbs_tb.sv */
`timescale 1ns/1ps

module prbs_tb;

    import prbs_pkg::*;

    localparam int CLK_PERIOD = 4;          // ns
    localparam int RAND_SEED  = 91579;
    localparam logic [TAPS_W-1:0] PRBS_DEFAULT_TAPS = {5'd4, 5'd13, 5'd15, 5'd16};  // Maximal length

    // Steps per test, used to size the watchdog
    localparam int T1_STEPS = 20;
    localparam int T2_STEPS = 500;
    localparam int T3_STEPS = 400;
    localparam int T4_STEPS = 65535;
    localparam int T5_STEPS = 100 + 200;
    localparam int T6_STEPS = 50;
    localparam int TOTAL_STEPS = T1_STEPS + T2_STEPS + T3_STEPS + T4_STEPS + T5_STEPS + T6_STEPS;
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS * 8 + 2000;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_cfg_wr;
    logic                  i_cfg_rd;
    logic [CFG_ADDR_W-1:0] i_cfg_addr;
    logic [CFG_DATA_W-1:0] i_cfg_wdata;
    logic [CFG_DATA_W-1:0] o_cfg_rdata;
    logic                  o_cfg_rvalid;
    logic                  i_tx_req;
    logic [PRBS_WIDTH-1:0] o_tx_data;
    logic                  o_tx_valid;
    logic                  i_rx_valid;
    logic [PRBS_WIDTH-1:0] i_rx_data;

    // Reference model state
    logic [PRBS_WIDTH-1:0] m_state;
    logic [PRBS_WIDTH-1:0] m_seed;
    logic [TAPS_W-1:0]     m_taps;
    int                    m_words;
    int                    m_err;
    int                    m_wraps;
    logic [PRBS_WIDTH-1:0] exp_q[$];   // Words requested, not yet seen

    string cur_test;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    int    seed_dummy;

    prbs_top dut_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_rd     (i_cfg_rd),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_cfg_rvalid (o_cfg_rvalid),
        .i_tx_req     (i_tx_req),
        .o_tx_data    (o_tx_data),
        .o_tx_valid   (o_tx_valid),
        .i_rx_valid   (i_rx_valid),
        .i_rx_data    (i_rx_data)
    );

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    ////////////////////
    // Model helpers
    ////////////////////

    // One Fibonacci step: tap p reads state bit p-1, feedback enters bit 0
    function automatic logic [PRBS_WIDTH-1:0] lfsr_step(input logic [PRBS_WIDTH-1:0] s,
                                                        input logic [TAPS_W-1:0] taps);
        logic [PRBS_WIDTH:1]    used;
        logic [TAP_INDEX_W-1:0] pos;
        logic                   fb;
        used = '0;
        fb   = 1'b0;
        for (int k = 0; k < TAP_COUNT; k++) begin
            pos = taps[k*TAP_INDEX_W +: TAP_INDEX_W];
            if (pos >= 1 && pos <= PRBS_WIDTH) used[pos] = 1'b1;  // Repeats count once
        end
        for (int p = 1; p <= PRBS_WIDTH; p++) begin
            if (used[p]) fb = fb ^ s[p-1];
        end
        return {s[PRBS_WIDTH-2:0], fb};
    endfunction

    function automatic int count_ones(input logic [PRBS_WIDTH-1:0] v);
        int n;
        n = 0;
        for (int b = 0; b < PRBS_WIDTH; b++) n += v[b];
        return n;
    endfunction

    function automatic logic [CNT_W-1:0] saturate(input int v);
        return (v >= (1 << CNT_W) - 1) ? '1 : CNT_W'(v);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            test_errors++;
        end
    endtask

    ////////////////////
    // Bus tasks
    ////////////////////

    task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
        i_cfg_wr    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(posedge i_clk);
        #1;
        i_cfg_wr    = 1'b0;
    endtask

    task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [CFG_DATA_W-1:0] data);
        int waited;
        waited     = 0;
        i_cfg_rd   = 1'b1;
        i_cfg_addr = addr;
        @(posedge i_clk);
        #1;
        i_cfg_rd   = 1'b0;
        while (!o_cfg_rvalid && waited < 8) begin  // Response is due now
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (!o_cfg_rvalid) begin
            $display("%s: register read of address %0d got no response", cur_test, addr);
            test_errors++;
        end
        data = o_cfg_rdata;
    endtask

    task automatic check_reg(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] exp);
        logic [CFG_DATA_W-1:0] data;
        cfg_read(addr, data);
        check_value($sformatf("%s reg %0d", cur_test, addr), exp, data);
    endtask

    // Program seed and taps, then start; returns once both LFSRs hold the seed
    task automatic start_pattern(input logic [PRBS_WIDTH-1:0] seed, input logic [TAPS_W-1:0] taps);
        cfg_write(ADDR_SEED, CFG_DATA_W'(seed));
        cfg_write(ADDR_TAPS, CFG_DATA_W'(taps));
        cfg_write(ADDR_CTRL, (1 << CTRL_EN_BIT) | (1 << CTRL_START_BIT));
        @(posedge i_clk);                                // Seed load cycle
        #1;
        m_state = seed;
        m_seed  = seed;
        m_taps  = taps;
        m_words = 0;
        m_err   = 0;
        m_wraps = 0;
    endtask

    ////////////////////
    // Traffic
    ////////////////////

    // Requests n words with random gaps and loops each one back to the checker
    task automatic run_words(input int n, input int gap_pct, input int err_pct);
        int                    issued;
        logic [PRBS_WIDTH-1:0] mask;
        issued = 0;
        while (issued < n || exp_q.size() > 0) begin
            i_rx_valid = 1'b0;
            if (o_tx_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: o_tx_valid rose with no request outstanding", cur_test);
                    test_errors++;
                end else begin
                    check_value({cur_test, " tx data"}, exp_q.pop_front(), o_tx_data);
                end
                mask = '0;
                if (($urandom % 100) < err_pct) mask = PRBS_WIDTH'($urandom % 65535) + 1'b1;
                i_rx_valid = 1'b1;
                i_rx_data  = o_tx_data ^ mask;          // Injected bit errors
                m_err   += count_ones(mask);
                m_words += 1;
            end
            i_tx_req = 1'b0;
            if (issued < n && ($urandom % 100) >= gap_pct) begin
                i_tx_req = 1'b1;
                issued++;
                m_state = lfsr_step(m_state, m_taps);
                if (m_state == m_seed) m_wraps++;       // Back on the seed
                exp_q.push_back(m_state);
            end
            @(posedge i_clk);
            #1;
        end
        i_rx_valid = 1'b0;
        i_tx_req   = 1'b0;
        repeat (3) @(posedge i_clk);                    // Let the counters settle
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: PASS", cur_test);
        end else begin
            tests_failed++;
            $display("%s: FAIL (%0d errors)", cur_test, test_errors);
        end
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [PRBS_WIDTH-1:0] seed_a;
        logic [PRBS_WIDTH-1:0] seed_b;
        logic [TAPS_W-1:0]     taps_b;
        int                    words_before;
        seed_dummy   = $urandom(RAND_SEED);
        tests_passed = 0;
        tests_failed = 0;
        i_rst_n      = 1'b1;                            // Reset asserted high
        i_cfg_wr     = 1'b0;
        i_cfg_rd     = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_wdata  = '0;
        i_tx_req     = 1'b0;
        i_rx_valid   = 1'b0;
        i_rx_data    = '0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;

        begin_test("reset_state");
        for (int a = 0; a < (1 << CFG_ADDR_W); a++) check_reg(CFG_ADDR_W'(a), 0);
        for (int c = 0; c < T1_STEPS; c++) begin
            i_tx_req = c[0];                            // Strobe while disabled
            @(posedge i_clk);
            #1;
            check_value({cur_test, " tx valid"}, 0, o_tx_valid);
        end
        i_tx_req = 1'b0;
        end_test();

        begin_test("pattern_match");
        start_pattern(PRBS_WIDTH'($urandom % 65535) + 1'b1, PRBS_DEFAULT_TAPS);
        run_words(T2_STEPS, 25, 0);
        check_reg(ADDR_WORD_CNT, T2_STEPS);
        check_reg(ADDR_ERR_CNT, 0);
        end_test();

        begin_test("error_count");
        start_pattern(PRBS_WIDTH'($urandom % 65535) + 1'b1, PRBS_DEFAULT_TAPS);
        run_words(T3_STEPS, 25, 25);
        check_reg(ADDR_ERR_CNT, saturate(m_err));
        check_reg(ADDR_WORD_CNT, saturate(m_words));
        end_test();

        // Errors on a full period push the error count past its top
        begin_test("full_wrap");
        start_pattern(PRBS_WIDTH'($urandom % 65535) + 1'b1, PRBS_DEFAULT_TAPS);
        run_words(T4_STEPS, 0, 25);
        check_value({cur_test, " generator on seed"}, m_seed, o_tx_data);
        check_reg(ADDR_WRAP_CNT, 1);
        check_reg(ADDR_WORD_CNT, saturate(m_words));
        check_reg(ADDR_ERR_CNT, saturate(m_err));
        end_test();

        begin_test("restart_mid_run");
        seed_a = PRBS_WIDTH'($urandom % 65535) + 1'b1;
        start_pattern(seed_a, TAPS_W'(16));             // Single tap rotates, wraps often
        run_words(100, 25, 10);
        seed_b = seed_a;
        while (seed_b == seed_a) seed_b = PRBS_WIDTH'($urandom % 65535) + 1'b1;
        taps_b = {TAP_INDEX_W'($urandom % 16), TAP_INDEX_W'($urandom % 16),
                  TAP_INDEX_W'($urandom % 16), TAP_INDEX_W'(16)};
        start_pattern(seed_b, taps_b);
        check_reg(ADDR_ERR_CNT, 0);                     // Cleared by start
        check_reg(ADDR_WORD_CNT, 0);
        check_reg(ADDR_WRAP_CNT, 0);
        run_words(200, 25, 0);
        check_reg(ADDR_ERR_CNT, 0);
        check_reg(ADDR_WORD_CNT, saturate(m_words));
        check_reg(ADDR_WRAP_CNT, CNT_W'(m_wraps));
        end_test();

        begin_test("disabled_requests");
        words_before = m_words;
        cfg_write(ADDR_CTRL, 0);                        // Enable off, no start
        for (int c = 0; c < T6_STEPS; c++) begin
            i_tx_req   = 1'b1;
            i_rx_valid = 1'b1;                          // Receive side must drop these too
            i_rx_data  = o_tx_data;
            @(posedge i_clk);
            #1;
            check_value({cur_test, " tx valid"}, 0, o_tx_valid);
        end
        i_tx_req   = 1'b0;
        i_rx_valid = 1'b0;
        repeat (3) @(posedge i_clk);
        #1;
        check_reg(ADDR_WORD_CNT, saturate(words_before));
        check_reg(ADDR_ERR_CNT, saturate(m_err));
        end_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : prbs_tb

/* project.f */
src/prbs_pkg.sv
src/lfsr_fibonacci.sv
src/prbs_cfg_regs.sv
src/prbs_checker.sv
src/prbs_top.sv
verification/prbs_tb.sv

/* Bender.yml */
package:
  name: prbs_pattern

dependencies: {}

sources:
  # RTL, package first
  - files:
      - src/prbs_pkg.sv
      - src/lfsr_fibonacci.sv
      - src/prbs_cfg_regs.sv
      - src/prbs_checker.sv
      - src/prbs_top.sv

  # Testbench
  - target: simulation
    files:
      - verification/prbs_tb.sv
